// ==== memSys_consts.svh ====
// memory subsystem constants
`ifndef MEM_SYS_CONSTS_SVH
`define MEM_SYS_CONSTS_SVH

// memory sizes in bytes, powers of two
`define MEM_ROM_SIZE 4096
`define MEM_RAM_SIZE 4096

// region select, address bits 31:28
`define MEM_ROM_BASE 4'h0
// timer registers live here
`define MEM_TIMER_BASE 4'h4
// data ram, program stack sits at 0x5000_0500
`define MEM_RAM_BASE 4'h5

// timer register byte offsets, address bits 3:0
`define TIMER_REG_CMP 4'h0
`define TIMER_REG_CNT 4'h4
`define TIMER_REG_CTRL 4'h8

// control register holds enable in bit 0 and pending in bit 1

// length of the built-in test program in words
`define ROM_PROG_WORDS 22

`endif

// ==== memPkg.sv ====
// memory subsystem types
`default_nettype none

package memPkg;

    // data word on every data path
    typedef logic [31:0] word;

    // byte lane enables, same order as wishbone sel
    // bit 0 is bits 7:0
    typedef logic [3:0] byteSel;

    // address decode result
    // regNone answers with an error
    typedef enum logic [1:0] {
        regNone  = 2'd0,
        regRom   = 2'd1,
        regRam   = 2'd2,
        regTimer = 2'd3
    } region;

endpackage

`default_nettype wire

// ==== busCtrl.sv ====
// wishbone bus control
`timescale 1ns/1ps
`default_nettype none

`include "memSys_consts.svh"

module busCtrl (
    input  logic        clk,
    input  logic        arstN,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [31:0] wbAdr,
    output memPkg::word wbDatR,
    output logic        wbAck,
    output logic        wbErr,
    input  memPkg::word romRdata,
    input  memPkg::word ramRdata,
    input  memPkg::word tmrRdata,
    output logic        ramWe,
    output logic        tmrWe
);
    import memPkg::*;

    // decode of the current address
    region decRegion;
    // region of the request being answered
    region regionQ;
    // first cycle of a request
    logic  newReq;
    // answer with err
    logic  badReq;

    // a request still facing its own answer is not taken again
    assign newReq = wbCyc & wbStb & ~wbAck & ~wbErr;

    // top nibble selects the block
    always_comb begin
        case (wbAdr[31:28])
            `MEM_ROM_BASE:   decRegion = regRom;
            `MEM_RAM_BASE:   decRegion = regRam;
            `MEM_TIMER_BASE: decRegion = regTimer;
            default:         decRegion = regNone;
        endcase
    end

    // unmapped, or a write to rom
    assign badReq = (decRegion == regNone) | ((decRegion == regRom) & wbWe);

    // one cycle write strobes, legal writes only
    assign ramWe = newReq & wbWe & (decRegion == regRam);
    assign tmrWe = newReq & wbWe & (decRegion == regTimer);

    // answer one cycle after the request is seen
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbAck   <= 1'b0;
            wbErr   <= 1'b0;
            regionQ <= regNone;
        end else begin
            wbAck <= newReq & ~badReq;
            wbErr <= newReq & badReq;
            if (newReq) begin
                regionQ <= decRegion;
            end
        end
    end

    // read mux, zero outside the ack cycle
    always_comb begin
        wbDatR = '0;
        if (wbAck) begin
            case (regionQ)
                // address still held, rom reads through
                regRom:   wbDatR = romRdata;
                regRam:   wbDatR = ramRdata;
                regTimer: wbDatR = tmrRdata;
                default:  wbDatR = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rom.sv ====
// instruction rom
`timescale 1ns/1ps
`default_nettype none

`include "memSys_consts.svh"

module rom #(
    parameter int unsigned MemSize = `MEM_ROM_SIZE
) (
    input  logic        clk,
    input  logic [31:0] fetchAddr,
    output memPkg::word fetchData,
    input  logic [31:0] busAddr,
    output memPkg::word busRdata
);
    import memPkg::*;

    // byte address width of the array
    localparam int AddrW = $clog2(MemSize);

    // timer test program
    // init sets up sp and enables interrupts, main installs isr_0 and
    // arms the timer, isr_0 toggles a flag word in ram
    localparam word Prog [`ROM_PROG_WORDS] = '{
        // init, sp to 0x5000_0500
        32'h50000117,
        32'h50010113,
        32'h35015073,
        // main, isr address into vector 1
        32'h30045073,
        32'h00000317,
        32'h02430313,
        32'h00235313,
        32'hb0031073,
        // timer config and priority
        32'h0f000393,
        32'h40039073,
        32'h01e00313,
        32'hb2031073,
        // stop, spin here
        32'h0000006f,
        // isr_0, flag address in t0
        32'h50000297,
        32'hfcc28293,
        // toggle flag
        32'h0002a303,
        32'h00134313,
        32'h00031073,
        32'h0062a023,
        // store cycle csr next to flag
        32'hb4002e73,
        32'h01c2a223,
        // ret
        32'h00008067
    };

    word mem [MemSize >> 2];

    // word index, bits 1:0 dropped
    logic [AddrW-3:0] fetchIdx;
    logic [AddrW-3:0] busIdx;

    assign fetchIdx = fetchAddr[AddrW-1:2];
    assign busIdx   = busAddr[AddrW-1:2];

    // both ports read asynchronously
    assign fetchData = mem[fetchIdx];
    assign busRdata  = mem[busIdx];

    initial begin
        // beyond the program reads as zero
        for (int k = 0; k < (MemSize >> 2); k++) begin
            mem[k] = '0;
        end
        for (int k = 0; k < `ROM_PROG_WORDS; k++) begin
            mem[k] = Prog[k];
        end
    end

endmodule

`default_nettype wire

// ==== dataRam.sv ====
// data ram
`timescale 1ns/1ps
`default_nettype none

`include "memSys_consts.svh"

module dataRam #(
    parameter int unsigned MemSize = `MEM_RAM_SIZE
) (
    input  logic           clk,
    input  logic           ramWe,
    input  logic [31:0]    busAddr,
    input  memPkg::word    wdata,
    input  memPkg::byteSel sel,
    output memPkg::word    rdata
);
    import memPkg::*;

    // byte address width
    localparam int AddrW = $clog2(MemSize);

    // word organized storage
    word mem [MemSize >> 2];

    logic [AddrW-3:0] wordIdx;

    // region bits above the ram size are ignored
    assign wordIdx = busAddr[AddrW-1:2];

    // per lane write
    always_ff @(posedge clk) begin
        if (ramWe) begin
            for (int i = 0; i < 4; i++) begin
                if (sel[i]) begin
                    mem[wordIdx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read, same address
    // read during write sees the old word
    always_ff @(posedge clk) begin
        rdata <= mem[wordIdx];
    end

endmodule

`default_nettype wire

// ==== cycleTimer.sv ====
// cycle timer
`timescale 1ns/1ps
`default_nettype none

`include "memSys_consts.svh"

module cycleTimer (
    input  logic        clk,
    input  logic        arstN,
    input  logic        tmrWe,
    input  logic [3:0]  regOffset,
    input  memPkg::word wdata,
    output memPkg::word rdata,
    output logic        irq
);
    import memPkg::*;

    word  cmpReg;
    word  cntReg;
    // control bits
    logic enable;
    logic pending;
    // counter reached compare
    logic hit;

    assign hit = enable & (cntReg == cmpReg);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cmpReg  <= '0;
            cntReg  <= '0;
            enable  <= 1'b0;
            pending <= 1'b0;
        end else begin
            // period wrap, pending is sticky
            if (hit) begin
                cntReg  <= '0;
                pending <= 1'b1;
            end else if (enable) begin
                cntReg <= cntReg + 32'd1;
            end
            // bus writes override the count
            if (tmrWe) begin
                case (regOffset)
                    `TIMER_REG_CMP: begin
                        cmpReg <= wdata;
                    end
                    `TIMER_REG_CNT: begin
                        cntReg <= wdata;
                    end
                    `TIMER_REG_CTRL: begin
                        enable <= wdata[0];
                        // write one to clear
                        if (wdata[1]) begin
                            pending <= 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // captured at the request edge, pre-write value
    always_ff @(posedge clk) begin
        case (regOffset)
            `TIMER_REG_CMP:  rdata <= cmpReg;
            `TIMER_REG_CNT:  rdata <= cntReg;
            `TIMER_REG_CTRL: rdata <= {30'd0, pending, enable};
            default:         rdata <= '0;
        endcase
    end

    assign irq = pending;

endmodule

`default_nettype wire

// ==== memSys.sv ====
// memory subsystem top
`timescale 1ns/1ps
`default_nettype none

module memSys (
    input  logic           clk,
    input  logic           arstN,
    // instruction fetch
    input  logic [31:0]    fetchAddr,
    output memPkg::word    fetchData,
    // wishbone classic slave
    input  logic           wbCyc,
    input  logic           wbStb,
    input  logic           wbWe,
    input  memPkg::byteSel wbSel,
    input  logic [31:0]    wbAdr,
    input  memPkg::word    wbDatW,
    output memPkg::word    wbDatR,
    output logic           wbAck,
    output logic           wbErr,
    // timer interrupt request
    output logic           timerIrq
);
    import memPkg::*;

    // block read words back to the bus mux
    word  romRdata;
    word  ramRdata;
    word  tmrRdata;
    // write strobes
    logic ramWe;
    logic tmrWe;

    busCtrl i_busCtrl (
        .clk      (clk),
        .arstN    (arstN),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatR   (wbDatR),
        .wbAck    (wbAck),
        .wbErr    (wbErr),
        .romRdata (romRdata),
        .ramRdata (ramRdata),
        .tmrRdata (tmrRdata),
        .ramWe    (ramWe),
        .tmrWe    (tmrWe)
    );

    rom i_rom (
        .clk       (clk),
        .fetchAddr (fetchAddr),
        .fetchData (fetchData),
        .busAddr   (wbAdr),
        .busRdata  (romRdata)
    );

    dataRam i_dataRam (
        .clk     (clk),
        .ramWe   (ramWe),
        .busAddr (wbAdr),
        .wdata   (wbDatW),
        .sel     (wbSel),
        .rdata   (ramRdata)
    );

    // register offset from the low address bits
    cycleTimer i_cycleTimer (
        .clk       (clk),
        .arstN     (arstN),
        .tmrWe     (tmrWe),
        .regOffset (wbAdr[3:0]),
        .wdata     (wbDatW),
        .rdata     (tmrRdata),
        .irq       (timerIrq)
    );

endmodule

`default_nettype wire

// ==== tbMemSys.sv ====
// memory subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "memSys_consts.svh"

module tbMemSys;
    import memPkg::*;

    // step kinds of the stimulus table
    typedef enum logic [1:0] {
        stFetch,
        stBus,
        stWait
    } stepKind;

    // one table entry
    // wait steps carry the cycle count in wdata and the expected irq in expData
    typedef struct packed {
        stepKind     kind;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expData;
        logic        expErr;
    } stepT;

    logic        clk = 1'b0;
    logic        arstN;
    logic [31:0] fetchAddr;
    word         fetchData;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    byteSel      wbSel;
    logic [31:0] wbAdr;
    word         wbDatW;
    word         wbDatR;
    logic        wbAck;
    logic        wbErr;
    logic        timerIrq;

    stepT steps[$];
    // expected ram contents for the words under test
    word  ramShadow [4];
    int   cycleCnt = 0;
    int   cycleLimit;

    memSys i_dut (
        .clk       (clk),
        .arstN     (arstN),
        .fetchAddr (fetchAddr),
        .fetchData (fetchData),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbSel     (wbSel),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .wbErr     (wbErr),
        .timerIrq  (timerIrq)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt > cycleLimit) begin
            $display("Timeout: run went past %0d cycles", cycleLimit);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    task automatic checkVal(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // per lane merge as wishbone sel defines it
    function automatic word mergeLanes(input word oldW, input word newW, input byteSel sel);
        word res;
        res = oldW;
        for (int k = 0; k < 4; k++) begin
            if (sel[k]) begin
                res[8*k +: 8] = newW[8*k +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] tmrAddr(input logic [3:0] offset);
        return {`MEM_TIMER_BASE, 24'h0, offset};
    endfunction

    function automatic logic [31:0] ramAddr(input int idx);
        return {`MEM_RAM_BASE, 28'h0000100} + idx * 4;
    endfunction

    task automatic pushStep(input stepKind kind, input logic we, input logic [3:0] sel,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] expData, input logic expErr);
        stepT s;
        s.kind    = kind;
        s.we      = we;
        s.sel     = sel;
        s.addr    = addr;
        s.wdata   = wdata;
        s.expData = expData;
        s.expErr  = expErr;
        steps.push_back(s);
    endtask

    task automatic busRead(input logic [31:0] addr, input word exp, input logic err);
        pushStep(stBus, 1'b0, 4'hF, addr, 32'h0, exp, err);
    endtask

    task automatic busWrite(input logic [31:0] addr, input byteSel sel, input word data,
                            input logic err);
        pushStep(stBus, 1'b1, sel, addr, data, 32'h0, err);
    endtask

    task automatic fetchCheck(input logic [31:0] addr, input word exp);
        pushStep(stFetch, 1'b0, 4'h0, addr, 32'h0, exp, 1'b0);
    endtask

    task automatic idleWait(input int cycles, input logic irq);
        pushStep(stWait, 1'b0, 4'h0, 32'h0, cycles, {31'd0, irq}, 1'b0);
    endtask

    task automatic buildTable();
        word    w;
        byteSel sel;
        // timer idle after reset
        busRead(tmrAddr(`TIMER_REG_CMP), 32'h0, 1'b0);
        busRead(tmrAddr(`TIMER_REG_CNT), 32'h0, 1'b0);
        busRead(tmrAddr(`TIMER_REG_CTRL), 32'h0, 1'b0);
        // program words on the fetch port, past the end reads zero
        fetchCheck(32'h0000_0000, 32'h50000117);
        fetchCheck(32'h0000_0030, 32'h0000006F);
        fetchCheck(32'h0000_0054, 32'h00008067);
        fetchCheck(32'h0000_0058, 32'h0);
        fetchCheck(32'h0000_0FFC, 32'h0);
        // same words over the bus
        busRead(32'h0000_0000, 32'h50000117, 1'b0);
        busRead(32'h0000_0030, 32'h0000006F, 1'b0);
        busRead(32'h0000_0054, 32'h00008067, 1'b0);
        busRead(32'h0000_0058, 32'h0, 1'b0);
        // full word writes
        for (int i = 0; i < 4; i++) begin
            w = $urandom;
            ramShadow[i] = w;
            busWrite(ramAddr(i), 4'hF, w, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            busRead(ramAddr(i), ramShadow[i], 1'b0);
        end
        // partial writes, low half or top byte
        for (int i = 0; i < 4; i++) begin
            w = $urandom;
            sel = i[0] ? 4'b1000 : 4'b0011;
            ramShadow[i] = mergeLanes(ramShadow[i], w, sel);
            busWrite(ramAddr(i), sel, w, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            busRead(ramAddr(i), ramShadow[i], 1'b0);
        end
        // rom is read only
        busWrite(32'h0000_0030, 4'hF, 32'hDEADBEEF, 1'b1);
        fetchCheck(32'h0000_0030, 32'h0000006F);
        busRead(32'h0000_0030, 32'h0000006F, 1'b0);
        // nibble 1 is unmapped
        busRead(32'h1000_0000, 32'h0, 1'b1);
        busWrite(32'h1000_0040, 4'hF, 32'h12345678, 1'b1);
        busRead(32'h1FFF_FFFC, 32'h0, 1'b1);
        // period of 21 cycles, irq well before 40
        busWrite(tmrAddr(`TIMER_REG_CMP), 4'hF, 32'd20, 1'b0);
        busWrite(tmrAddr(`TIMER_REG_CTRL), 4'hF, 32'h1, 1'b0);
        idleWait(40, 1'b1);
        busRead(tmrAddr(`TIMER_REG_CTRL), 32'h3, 1'b0);
        // clear pending and stop
        busWrite(tmrAddr(`TIMER_REG_CTRL), 4'hF, 32'h2, 1'b0);
        idleWait(1, 1'b0);
        // stopped counter holds a loaded value
        busWrite(tmrAddr(`TIMER_REG_CNT), 4'hF, 32'd7, 1'b0);
        busRead(tmrAddr(`TIMER_REG_CNT), 32'd7, 1'b0);
        idleWait(5, 1'b0);
        busRead(tmrAddr(`TIMER_REG_CNT), 32'd7, 1'b0);
        busRead(tmrAddr(`TIMER_REG_CMP), 32'd20, 1'b0);
        busRead(tmrAddr(`TIMER_REG_CTRL), 32'h0, 1'b0);
    endtask

    task automatic applyFetch(input stepT s);
        @(posedge clk);
        fetchAddr <= s.addr;
        @(negedge clk);
        checkVal("fetchData", fetchData, s.expData);
    endtask

    task automatic doBusCycle(input stepT s);
        int lat;
        lat = 0;
        @(posedge clk);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= s.we;
        wbSel  <= s.sel;
        wbAdr  <= s.addr;
        wbDatW <= s.wdata;
        @(negedge clk);
        while (!(wbAck || wbErr)) begin
            lat++;
            if (lat > 4) begin
                $display("No bus answer within 4 cycles for address %h", s.addr);
                $display("Done: errors found");
                $fatal(1);
            end
            @(negedge clk);
        end
        // answer belongs to the cycle after the request
        if (lat != 1) begin
            $display("Bus answer for address %h came after %0d cycles instead of 1",
                     s.addr, lat);
            $display("Done: errors found");
            $fatal(1);
        end
        checkVal("wbAck", {31'd0, wbAck}, {31'd0, ~s.expErr});
        checkVal("wbErr", {31'd0, wbErr}, {31'd0, s.expErr});
        if (!s.we) begin
            checkVal("wbDatR", wbDatR, s.expData);
        end
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
        @(negedge clk);
        // single cycle answer, data bus back to zero
        checkVal("wbAck", {31'd0, wbAck}, 32'h0);
        checkVal("wbErr", {31'd0, wbErr}, 32'h0);
        checkVal("wbDatR", wbDatR, 32'h0);
    endtask

    task automatic idleCycles(input stepT s);
        repeat (s.wdata) @(posedge clk);
        @(negedge clk);
        checkVal("timerIrq", {31'd0, timerIrq}, s.expData);
    endtask

    initial begin
        stepT cur;
        int   waitSum;
        arstN     = 1'b0;
        fetchAddr = 32'h0;
        wbCyc     = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbSel     = 4'h0;
        wbAdr     = 32'h0;
        wbDatW    = 32'h0;
        void'($urandom(71730));
        buildTable();
        waitSum = 0;
        foreach (steps[i]) begin
            if (steps[i].kind == stWait) begin
                waitSum += int'(steps[i].wdata);
            end
        end
        cycleLimit = steps.size() * 8 + waitSum + 50;
        // two cycles of reset
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkVal("wbAck", {31'd0, wbAck}, 32'h0);
        checkVal("wbErr", {31'd0, wbErr}, 32'h0);
        checkVal("timerIrq", {31'd0, timerIrq}, 32'h0);
        for (int i = 0; i < steps.size(); i++) begin
            cur = steps[i];
            case (cur.kind)
                stFetch: applyFetch(cur);
                stBus:   doBusCycle(cur);
                default: idleCycles(cur);
            endcase
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== memSys.f ====
+incdir+.
memPkg.sv
busCtrl.sv
rom.sv
dataRam.sv
cycleTimer.sv
memSys.sv
tbMemSys.sv

// ==== runSim.sh ====
#!/bin/sh
# builds and runs the memSys testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f memSys.f --top-module tbMemSys -o simMemSys

# the log decides pass or fail, not the exit status
./obj_dir/simMemSys > simMemSys.log 2>&1 || true
cat simMemSys.log

if grep -q "Done: errors found" simMemSys.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Done: no errors" simMemSys.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
